// ==== design/siggen_pkg.sv ====
/*
 shared sizes, register map and stage structs of the waveform generator
*/
`default_nettype none

package siggen_pkg;

	// envelope table
	localparam int TABLE_DEPTH = 256;
	localparam int TABLE_AW = $clog2(TABLE_DEPTH);

	// command queue
	localparam int QUEUE_DEPTH = 4;
	localparam int QPTR_W = $clog2(QUEUE_DEPTH);
	localparam int QCNT_W = QPTR_W + 1;

	// wishbone word addresses
	localparam logic [1:0] REG_MEM_ADDR = 2'd0;
	localparam logic [1:0] REG_MEM_DATA = 2'd1;
	localparam logic [1:0] REG_STATUS = 2'd2;

	// sample width and full scale of the triangle
	localparam int SAMPLE_W = 16;
	localparam logic signed [SAMPLE_W-1:0] TRI_MAX = 16'sd32767;

	// one queued waveform, 109 bits
	typedef struct packed {
		logic [31:0] freq;
		logic [31:0] phase;
		logic [TABLE_AW-1:0] addr;
		logic signed [SAMPLE_W-1:0] gain;
		logic [15:0] nsamp;
		logic [1:0] outsel;
		logic mode;
		logic stdysel;
		logic phrst;
	} wave_cmd_t;

	// decode to execute
	typedef struct packed {
		logic active;
		logic [31:0] inc;
		logic [31:0] phase;
		logic phrst;
		logic [TABLE_AW-1:0] addr;
		logic signed [SAMPLE_W-1:0] gain;
		logic [1:0] outsel;
		logic stdysel;
	} exec_req_t;

	// execute to result
	typedef struct packed {
		logic active;
		logic signed [SAMPLE_W-1:0] value;
		logic signed [SAMPLE_W-1:0] gain;
		logic stdysel;
	} shape_t;

endpackage

`default_nettype wire

// ==== design/wave_regs.sv ====
/*
 wishbone classic slave, envelope table ram with write pointer,
 status read and the pipeline read port
*/
`timescale 1ns/10ps
`default_nettype none

module wave_regs import siggen_pkg::*; (
	input wire logic aclk,
	input wire logic rst_n,
	input wire logic cyc,
	input wire logic stb,
	input wire logic we,
	input wire logic [1:0] adr,
	input wire logic [31:0] dat_w,
	output logic ack,
	output logic [31:0] dat_r,
	input wire logic [TABLE_AW-1:0] table_raddr,
	output logic signed [SAMPLE_W-1:0] table_rdata,
	input wire logic [QCNT_W-1:0] queue_count,
	input wire logic busy
);

	logic signed [SAMPLE_W-1:0] mem [TABLE_DEPTH];
	logic [TABLE_AW-1:0] wptr;
	logic access;
	logic wr_acc;
	logic rd_acc;

	// new cycle seen while ack is still low
	assign access = cyc & stb & ~ack;
	assign wr_acc = access & we;
	assign rd_acc = access & ~we;

	// single cycle ack and write pointer
	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			ack <= 1'b0;
			wptr <= '0;
		end else begin
			ack <= access;
			if (wr_acc && adr == REG_MEM_ADDR) begin
				wptr <= dat_w[TABLE_AW-1:0];
			end else if (wr_acc && adr == REG_MEM_DATA) begin
				// auto increment after each data word
				wptr <= wptr + 1'b1;
			end
		end
	end

	// table write from the bus, read for the pipeline
	always_ff @(posedge aclk) begin
		if (wr_acc && adr == REG_MEM_DATA) begin
			mem[wptr] <= dat_w[SAMPLE_W-1:0];
		end
		table_rdata <= mem[table_raddr];
	end

	// read data lands with ack
	always_ff @(posedge aclk) begin
		if (rd_acc) begin
			case (adr)
				REG_MEM_ADDR: dat_r <= {{(32-TABLE_AW){1'b0}}, wptr};
				// fill count low, busy at bit 8
				REG_STATUS: dat_r <= {23'd0, busy, {(8-QCNT_W){1'b0}}, queue_count};
				default: dat_r <= 32'd0;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/wave_decode.sv ====
/*
 command queue and sample sequencer, one request per clock,
 periodic replay when nothing else is queued
*/
`timescale 1ns/10ps
`default_nettype none

module wave_decode import siggen_pkg::*; (
	input wire logic aclk,
	input wire logic rst_n,
	input wire wave_cmd_t cmd,
	input wire logic cmd_valid,
	output logic cmd_ready,
	output exec_req_t req,
	output logic [TABLE_AW-1:0] table_raddr,
	output logic [QCNT_W-1:0] queue_count,
	output logic busy
);

	wave_cmd_t q_mem [QUEUE_DEPTH];
	logic [QPTR_W-1:0] wr_ptr;
	logic [QPTR_W-1:0] rd_ptr;
	logic [QCNT_W-1:0] count;
	logic [QCNT_W-1:0] count_nxt;

	// current waveform
	wave_cmd_t cur;
	logic playing;
	logic first;
	logic [15:0] k;
	logic last;
	logic push;
	logic pop;

	assign push = cmd_valid & cmd_ready;
	assign last = playing && (k == cur.nsamp - 16'd1);
	// take the next command when idle or on the final sample
	assign pop = (!playing || last) && (count != '0);

	// table address goes out with the request it belongs to
	assign table_raddr = cur.addr + k[TABLE_AW-1:0];
	assign queue_count = count;
	assign busy = playing | (count != '0);

	always_comb begin
		count_nxt = count;
		if (push && !pop) begin
			count_nxt = count + 1'b1;
		end else if (pop && !push) begin
			count_nxt = count - 1'b1;
		end
	end

	// queue storage and current command
	always_ff @(posedge aclk) begin
		if (push) begin
			q_mem[wr_ptr] <= cmd;
		end
		if (pop) begin
			cur <= q_mem[rd_ptr];
		end
	end

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			cmd_ready <= 1'b0;
			playing <= 1'b0;
			first <= 1'b0;
			k <= '0;
			req <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count_nxt;
			// registered so ready stays low through reset
			cmd_ready <= (count_nxt != QCNT_W'(QUEUE_DEPTH));

			if (playing) begin
				req.active <= 1'b1;
				req.inc <= cur.freq;
				req.phase <= cur.phase;
				// phase reset only on the first sample
				req.phrst <= first & cur.phrst;
				req.addr <= table_raddr;
				req.gain <= cur.gain;
				req.outsel <= cur.outsel;
				req.stdysel <= cur.stdysel;
				first <= 1'b0;
			end else begin
				// other fields hold, stdysel stays for steady state
				req.active <= 1'b0;
			end

			if (pop) begin
				playing <= 1'b1;
				first <= 1'b1;
				k <= '0;
			end else if (last) begin
				// replay keeps the phase running
				if (cur.mode) begin
					k <= '0;
				end else begin
					playing <= 1'b0;
				end
			end else if (playing) begin
				k <= k + 16'd1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/wave_execute.sv ====
/*
 phase accumulator, triangle from the phase and envelope product
*/
`timescale 1ns/10ps
`default_nettype none

module wave_execute import siggen_pkg::*; (
	input wire logic aclk,
	input wire logic rst_n,
	input wire exec_req_t req,
	input wire logic signed [SAMPLE_W-1:0] table_rdata,
	output shape_t shp
);

	logic [31:0] acc;
	logic [31:0] acc_cur;
	logic [31:0] ph;
	logic [1:0] quad;
	logic [SAMPLE_W-2:0] u;
	logic signed [SAMPLE_W-1:0] tri_val;
	logic signed [2*SAMPLE_W-1:0] env_prod;
	logic signed [2*SAMPLE_W-1:0] env_sh;
	logic signed [SAMPLE_W-1:0] shape_val;

	// accumulator value seen by this sample
	assign acc_cur = req.phrst ? 32'd0 : acc;
	assign ph = acc_cur + req.phase;
	assign quad = ph[31:30];
	assign u = ph[29:15];

	// fold phase into a triangle
	always_comb begin
		case (quad)
			2'd0: tri_val = $signed({1'b0, u});
			2'd1: tri_val = TRI_MAX - $signed({1'b0, u});
			2'd2: tri_val = -$signed({1'b0, u});
			default: tri_val = $signed({1'b0, u}) - TRI_MAX;
		endcase
	end

	// q15 product with the envelope
	assign env_prod = tri_val * table_rdata;
	assign env_sh = env_prod >>> 15;

	always_comb begin
		case (req.outsel)
			2'd1: shape_val = tri_val;
			2'd2: shape_val = table_rdata;
			// 0 and the unused code give the product
			default: shape_val = env_sh[SAMPLE_W-1:0];
		endcase
	end

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			acc <= '0;
			shp <= '0;
		end else begin
			// advance only on real samples
			if (req.active) begin
				acc <= acc_cur + req.inc;
			end
			shp.active <= req.active;
			shp.value <= shape_val;
			shp.gain <= req.gain;
			shp.stdysel <= req.stdysel;
		end
	end

endmodule

`default_nettype wire

// ==== design/wave_result.sv ====
/*
 gain scaling and output register with steady state hold or zero
*/
`timescale 1ns/10ps
`default_nettype none

module wave_result import siggen_pkg::*; (
	input wire logic aclk,
	input wire logic rst_n,
	input wire shape_t shp,
	output logic signed [SAMPLE_W-1:0] dout,
	output logic dout_valid
);

	logic signed [2*SAMPLE_W-1:0] gain_prod;
	logic signed [2*SAMPLE_W-1:0] gain_sh;

	// q15 gain, truncated back to sample width
	assign gain_prod = $signed(shp.value) * $signed(shp.gain);
	assign gain_sh = gain_prod >>> 15;

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			dout <= '0;
			dout_valid <= 1'b0;
		end else begin
			dout_valid <= shp.active;
			if (shp.active) begin
				dout <= gain_sh[SAMPLE_W-1:0];
			end else if (shp.stdysel) begin
				// zero steady state
				dout <= '0;
			end
			// otherwise last sample stays on the output
		end
	end

endmodule

`default_nettype wire

// ==== design/siggen_top.sv ====
/*
 waveform generator top, register block and decode, execute, result stages
*/
`timescale 1ns/10ps
`default_nettype none

module siggen_top import siggen_pkg::*; (
	input wire logic aclk,
	input wire logic rst_n,
	input wire logic cyc,
	input wire logic stb,
	input wire logic we,
	input wire logic [1:0] adr,
	input wire logic [31:0] dat_w,
	output logic ack,
	output logic [31:0] dat_r,
	input wire wave_cmd_t cmd,
	input wire logic cmd_valid,
	output logic cmd_ready,
	output logic signed [SAMPLE_W-1:0] dout,
	output logic dout_valid
);

	logic [TABLE_AW-1:0] table_raddr;
	logic signed [SAMPLE_W-1:0] table_rdata;
	logic [QCNT_W-1:0] queue_count;
	logic busy;
	exec_req_t req;
	shape_t shp;

	// configuration and envelope table
	wave_regs u_regs (
		.aclk(aclk),
		.rst_n(rst_n),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.dat_w(dat_w),
		.ack(ack),
		.dat_r(dat_r),
		.table_raddr(table_raddr),
		.table_rdata(table_rdata),
		.queue_count(queue_count),
		.busy(busy)
	);

	wave_decode u_decode (
		.aclk(aclk),
		.rst_n(rst_n),
		.cmd(cmd),
		.cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready),
		.req(req),
		.table_raddr(table_raddr),
		.queue_count(queue_count),
		.busy(busy)
	);

	// table data arrives together with req
	wave_execute u_execute (
		.aclk(aclk),
		.rst_n(rst_n),
		.req(req),
		.table_rdata(table_rdata),
		.shp(shp)
	);

	wave_result u_result (
		.aclk(aclk),
		.rst_n(rst_n),
		.shp(shp),
		.dout(dout),
		.dout_valid(dout_valid)
	);

endmodule

`default_nettype wire

// ==== bench/siggen_checker.sv ====
/*
 bound assertions on wishbone ack, command handshake and reset output
*/
`timescale 1ns/10ps
`default_nettype none

module siggen_checker import siggen_pkg::*; (
	input wire logic aclk,
	input wire logic rst_n,
	input wire logic cyc,
	input wire logic stb,
	input wire logic ack,
	input wire wave_cmd_t cmd,
	input wire logic cmd_valid,
	input wire logic cmd_ready,
	input wire logic dout_valid
);

	// single cycle ack
	ack_single: assert property (@(posedge aclk) disable iff (!rst_n) ack |=> !ack)
		else $error("ack held for more than one cycle");

	// ack answers a strobe from the cycle before
	ack_after_stb: assert property (@(posedge aclk) disable iff (!rst_n)
		ack |-> $past(cyc && stb))
		else $error("ack without a preceding strobe");

	// stalled command must not change
	cmd_hold: assert property (@(posedge aclk) disable iff (!rst_n)
		cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd))
		else $error("command changed or dropped while stalled");

	reset_quiet: assert property (@(posedge aclk) !rst_n |=> !dout_valid)
		else $error("dout_valid high during reset");

endmodule

bind siggen_top siggen_checker u_checker (
	.aclk(aclk),
	.rst_n(rst_n),
	.cyc(cyc),
	.stb(stb),
	.ack(ack),
	.cmd(cmd),
	.cmd_valid(cmd_valid),
	.cmd_ready(cmd_ready),
	.dout_valid(dout_valid)
);

`default_nettype wire

// ==== bench/siggen_tb.sv ====
/*
 testbench with command table, sample reference model, checks and report
*/
`timescale 1ns/10ps
`default_nettype none

module siggen_tb import siggen_pkg::*; ();

	logic aclk;
	logic rst_n;
	logic cyc;
	logic stb;
	logic we;
	logic ack;
	logic [1:0] adr;
	logic [31:0] dat_w;
	logic [31:0] dat_r;
	wave_cmd_t cmd;
	logic cmd_valid;
	logic cmd_ready;
	logic signed [SAMPLE_W-1:0] dout;
	logic dout_valid;

	// reference model state
	logic signed [SAMPLE_W-1:0] env_m [TABLE_DEPTH];
	wave_cmd_t cmd_tab[$];
	int gap_tab[$];
	wave_cmd_t mq[$];
	int unsigned mstamp[$];
	wave_cmd_t cur_m;
	logic have_cur = 1'b0;
	int unsigned k_m = 0;
	logic [31:0] acc_m = '0;
	logic signed [SAMPLE_W-1:0] idle_exp = '0;
	int unsigned cyc_cnt = 0;
	int unsigned limit_cycles = 0;
	int unsigned samples_seen = 0;
	int mismatches = 0;
	int failures = 0;
	logic ready_low_seen = 1'b0;

	siggen_top uut (
		.aclk(aclk), .rst_n(rst_n), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
		.dat_w(dat_w), .ack(ack), .dat_r(dat_r), .cmd(cmd), .cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready), .dout(dout), .dout_valid(dout_valid)
	);

	initial begin
		aclk = 1'b0;
		forever #5 aclk = ~aclk;
	end

	always @(posedge aclk) cyc_cnt <= cyc_cnt + 1;

	// sample rule: triangle from the phase, envelope, product and gain
	function automatic logic signed [SAMPLE_W-1:0] expect_sample(wave_cmd_t c,
			int unsigned k, logic [31:0] acc);
		logic [31:0] ph;
		int u;
		int tri_v;
		int env;
		int prod;
		logic signed [SAMPLE_W-1:0] shape;
		ph = acc + c.phase;
		u = int'(ph[29:15]);
		case (ph[31:30])
			2'd0: tri_v = u;
			2'd1: tri_v = 32767 - u;
			2'd2: tri_v = -u;
			default: tri_v = u - 32767;
		endcase
		env = env_m[(int'(c.addr) + k) % TABLE_DEPTH];
		prod = tri_v * env;
		case (c.outsel)
			2'd1: shape = SAMPLE_W'(tri_v);
			2'd2: shape = SAMPLE_W'(env);
			default: shape = SAMPLE_W'(prod >>> 15);
		endcase
		prod = shape * $signed(c.gain);
		return SAMPLE_W'(prod >>> 15);
	endfunction

	// one table row, flags are mode, stdysel, phrst
	task automatic add_entry(input logic [31:0] freq, input logic [31:0] phase,
			input logic [7:0] addr, input logic [15:0] gain, input logic [15:0] nsamp,
			input logic [1:0] outsel, input logic [2:0] flags, input int gap);
		cmd_tab.push_back({freq, phase, addr, gain, nsamp, outsel, flags});
		gap_tab.push_back(gap);
	endtask

	task automatic wishbone_access(input logic write, input logic [1:0] addr,
			input logic [31:0] data, output logic [31:0] rdata);
		int waited;
		waited = 0;
		@(posedge aclk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= write;
		adr <= addr;
		dat_w <= data;
		@(posedge aclk);
		while (!ack && waited < 16) begin
			waited++;
			@(posedge aclk);
		end
		if (!ack) begin
			failures++;
			$display("no wishbone ack for address %0d at %0t", addr, $time);
		end
		rdata = dat_r;
		cyc <= 1'b0;
		stb <= 1'b0;
		we <= 1'b0;
	endtask

	// hold the command until the queue takes it, note the edge for the model
	task automatic send_cmd(input wave_cmd_t c);
		@(posedge aclk);
		cmd <= c;
		cmd_valid <= 1'b1;
		@(posedge aclk);
		while (!cmd_ready) begin
			ready_low_seen = 1'b1;
			@(posedge aclk);
		end
		mq.push_back(c);
		mstamp.push_back(cyc_cnt);
		cmd_valid <= 1'b0;
	endtask

	task automatic wait_idle();
		@(posedge aclk);
		while (mq.size() != 0 || !have_cur || k_m != cur_m.nsamp || cur_m.mode || dout_valid)
			@(posedge aclk);
	endtask

	// output monitor, a queued command is due 5 edges after its push
	always @(negedge aclk) begin : monitor
		logic signed [SAMPLE_W-1:0] exp_val;
		if (rst_n && dout_valid) begin
			if (!have_cur || k_m == cur_m.nsamp) begin
				if (mq.size() > 0 && mstamp[0] + 5 <= cyc_cnt) begin
					cur_m = mq.pop_front();
					void'(mstamp.pop_front());
					have_cur = 1'b1;
					k_m = 0;
					if (cur_m.phrst)
						acc_m = '0;
				end else if (have_cur && cur_m.mode) begin
					k_m = 0;
				end else begin
					failures++;
					$display("sample at %0t has no command to belong to", $time);
				end
			end
			exp_val = expect_sample(cur_m, k_m, acc_m);
			if (dout !== exp_val) begin
				mismatches++;
				$display("mismatch at %0t: sample %0d is %0d, expected %0d",
					$time, k_m, dout, exp_val);
			end
			acc_m = acc_m + cur_m.freq;
			k_m++;
			samples_seen++;
			idle_exp = cur_m.stdysel ? '0 : exp_val;
		end else if (rst_n) begin
			if (have_cur && (k_m < cur_m.nsamp || cur_m.mode)) begin
				failures++;
				$display("output gap inside a waveform at %0t", $time);
			end else if (mq.size() > 0 && mstamp[0] + 5 <= cyc_cnt) begin
				failures++;
				$display("queued command did not start at %0t", $time);
			end
			if (dout !== idle_exp) begin
				mismatches++;
				$display("mismatch at %0t: idle output %0d, expected %0d",
					$time, dout, idle_exp);
			end
		end
	end

	initial begin
		wait (limit_cycles != 0);
		repeat (limit_cycles) @(posedge aclk);
		$display("watchdog expired after %0d cycles", limit_cycles);
		$display("sim failed");
		$finish;
	end

	initial begin
		logic [31:0] rd;
		int unsigned sum;
		void'($urandom(32'hdda));
		rst_n = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		dat_w = '0;
		cmd = '0;
		cmd_valid = 1'b0;
		for (int i = 0; i < TABLE_DEPTH; i++)
			env_m[i] = SAMPLE_W'($urandom);
		// table readback, then a triangle crossing a quarter every 16 samples
		add_entry(32'd0, 32'd0, 8'd0, 16'sd32767, 16'd256, 2'd2, 3'b001, 0);
		add_entry(32'h0400_0000, 32'd0, 8'd0, 16'sd32767, 16'd70, 2'd1, 3'b011, -1);
		// products back to back, phase carried when phrst is clear
		add_entry($urandom, $urandom, 8'd5, 16'sd20000, 16'd24, 2'd0, 3'b001, -1);
		add_entry($urandom, 32'd0, 8'd200, -16'sd12345, 16'd30, 2'd0, 3'b000,
			int'($urandom_range(4, 0)));
		add_entry($urandom, $urandom, 8'd250, 16'sh8000, 16'd20, 2'd0, 3'b010,
			int'($urandom_range(4, 0)));
		// periodic replay until the next command
		add_entry(32'h0123_4567, 32'd0, 8'd16, 16'sd30000, 16'd10, 2'd0, 3'b101, -1);
		add_entry(32'h0200_0000, 32'h4000_0000, 8'd0, 16'sd16384, 16'd12, 2'd1, 3'b000, 35);
		// long waveform, five pushes behind it fill the queue
		add_entry(32'h0010_0000, 32'd0, 8'd32, 16'sd25000, 16'd40, 2'd0, 3'b001, 0);
		for (int i = 0; i < 5; i++)
			add_entry($urandom, $urandom, 8'($urandom), 16'($urandom), 16'(4 + i),
				2'(i % 3), {1'b0, i == 4, 1'b0}, 0);
		sum = 4 * TABLE_DEPTH + 200;
		for (int i = 0; i < cmd_tab.size(); i++)
			sum += cmd_tab[i].nsamp + ((gap_tab[i] > 0) ? gap_tab[i] : 0) + 8;
		limit_cycles = sum;

		repeat (8) @(posedge aclk);
		rst_n <= 1'b1;
		wishbone_access(1'b1, REG_MEM_ADDR, 32'd0, rd);
		for (int i = 0; i < TABLE_DEPTH; i++)
			wishbone_access(1'b1, REG_MEM_DATA, {16'd0, env_m[i]}, rd);
		wishbone_access(1'b0, REG_STATUS, 32'd0, rd);
		if (rd[2:0] != 3'd0 || rd[8]) begin
			mismatches++;
			$display("mismatch at %0t: status %h, expected empty and idle", $time, rd);
		end
		// pointer wraps back to the start after a full table
		wishbone_access(1'b0, REG_MEM_ADDR, 32'd0, rd);
		if (rd[7:0] != 8'd0) begin
			mismatches++;
			$display("mismatch at %0t: write pointer %0d, expected 0", $time, rd[7:0]);
		end

		for (int i = 0; i < cmd_tab.size(); i++) begin
			if (gap_tab[i] < 0)
				wait_idle();
			else
				repeat (gap_tab[i]) @(posedge aclk);
			send_cmd(cmd_tab[i]);
		end
		wait_idle();
		repeat (4) @(posedge aclk);
		if (!ready_low_seen) begin
			failures++;
			$display("cmd_ready never fell while the queue was full");
		end
		$display("errors: %0d mismatches, %0d other failures, %0d samples checked",
			mismatches, failures, samples_seen);
		if (mismatches == 0 && failures == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/siggen_pkg.sv
design/wave_regs.sv
design/wave_decode.sv
design/wave_execute.sv
design/wave_result.sv
design/siggen_top.sv
bench/siggen_checker.sv
bench/siggen_tb.sv

// ==== Makefile ====
SIM = obj_dir/Vsiggen_tb

all: run

$(SIM): vlog.f $(wildcard design/*.sv) $(wildcard bench/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module siggen_tb -f vlog.f

run: $(SIM)
	./$(SIM) 2>&1 | tee sim.log
	! grep -q "sim failed" sim.log
	grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
